//--- list.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
main_control.sv
register_bank.sv
stage_reg.sv
decode_stage.sv
execute_stage.sv
mips_core_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Result: PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_COUNT = 2000;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic        instr_ready;
	logic [31:0] instr;
	logic [31:0] next_pc;
	logic        res_valid;
	logic        res_ready;
	logic [31:0] res_alu;
	logic [31:0] res_store_data;
	logic [4:0]  res_dest;
	logic        res_reg_write;
	logic        res_mem_read;
	logic        res_mem_write;
	logic        res_branch_taken;
	logic [31:0] res_branch_target;
	logic [31:0] res_next_pc;
	logic        check_latency;
	logic        backpressure_on;
	logic        aborted;
	logic [31:0] pc;
	int          sent;
	int          stim_errors;
	int          chk_results;
	int          chk_errors;

	tb_clock_gen u_clock_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	mips_core_top u_dut (
		.i_clk               (clk),
		.i_rst_n             (rst_n),
		.i_instr_valid       (instr_valid),
		.o_instr_ready       (instr_ready),
		.i_instr             (instr),
		.i_next_pc           (next_pc),
		.o_res_valid         (res_valid),
		.i_res_ready         (res_ready),
		.o_res_alu           (res_alu),
		.o_res_store_data    (res_store_data),
		.o_res_dest          (res_dest),
		.o_res_reg_write     (res_reg_write),
		.o_res_mem_read      (res_mem_read),
		.o_res_mem_write     (res_mem_write),
		.o_res_branch_taken  (res_branch_taken),
		.o_res_branch_target (res_branch_target),
		.o_res_next_pc       (res_next_pc)
	);

	tb_checker u_checker (
		.i_clk               (clk),
		.i_rst_n             (rst_n),
		.i_instr_valid       (instr_valid),
		.i_instr_ready       (instr_ready),
		.i_instr             (instr),
		.i_next_pc           (next_pc),
		.i_res_valid         (res_valid),
		.i_res_ready         (res_ready),
		.i_res_alu           (res_alu),
		.i_res_store_data    (res_store_data),
		.i_res_dest          (res_dest),
		.i_res_reg_write     (res_reg_write),
		.i_res_mem_read      (res_mem_read),
		.i_res_mem_write     (res_mem_write),
		.i_res_branch_taken  (res_branch_taken),
		.i_res_branch_target (res_branch_target),
		.i_res_next_pc       (res_next_pc),
		.i_check_latency     (check_latency),
		.o_results           (chk_results),
		.o_errors            (chk_errors)
	);

	// ========================================================================
	// instruction encoding and stimulus helpers
	// ========================================================================
	function automatic logic [31:0] encode_rtype(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {mips_isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// few registers so that dependencies and r0 writes are frequent
	function automatic logic [31:0] random_instr();
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		rs  = 5'($urandom % 8);
		rt  = 5'($urandom % 8);
		rd  = 5'($urandom % 8);
		imm = 16'($urandom);
		case ($urandom % 10)
			0:       return encode_rtype(mips_isa_pkg::FN_ADD, rd, rs, rt);
			1:       return encode_rtype(mips_isa_pkg::FN_SUB, rd, rs, rt);
			2:       return encode_rtype(mips_isa_pkg::FN_AND, rd, rs, rt);
			3:       return encode_rtype(mips_isa_pkg::FN_OR, rd, rs, rt);
			4:       return encode_rtype(mips_isa_pkg::FN_SLT, rd, rs, rt);
			5:       return encode_itype(mips_isa_pkg::OP_ADDI, rs, rt, imm);
			6:       return encode_itype(mips_isa_pkg::OP_LW, rs, rt, imm);
			7:       return encode_itype(mips_isa_pkg::OP_SW, rs, rt, imm);
			8:       return encode_itype(mips_isa_pkg::OP_BEQ, rs, rt, imm);
			default: return encode_itype(6'h3f, rs, rt, imm);
		endcase
	endfunction

	task automatic report_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		stim_errors++;
		aborted = 1'b1;
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %h, got %h", name, expected, actual);
			stim_errors++;
		end
	endtask

	// called 1 ns after an edge and returns 1 ns after the accepting edge
	task automatic send_instr(input logic [31:0] word);
		logic accepted;
		int   waited;
		pc          = pc + 32'd4;
		instr_valid = 1'b1;
		instr       = word;
		next_pc     = pc;
		accepted    = 1'b0;
		waited      = 0;
		while (!accepted && !aborted) begin
			@(negedge clk);
			accepted = instr_ready;
			@(posedge clk);
			#1;
			if (!accepted) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					report_timeout("o_instr_ready");
				end
			end
		end
		if (accepted && check_latency && (waited != 0)) begin
			$display("ERROR: input stalled %0d cycles while results were always taken", waited);
			stim_errors++;
		end
		instr_valid = 1'b0;
		if (accepted) begin
			sent++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((chk_results != sent) && !aborted) begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("all results to retire");
			end
		end
	endtask

	// result side stalls at random only when enabled
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (backpressure_on) begin
				res_ready = (($urandom % 4) != 0);
			end else begin
				res_ready = 1'b1;
			end
		end
	end

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		int waited;
		void'($urandom(32'h9812));
		instr_valid     = 1'b0;
		instr           = '0;
		next_pc         = '0;
		res_ready       = 1'b1;
		check_latency   = 1'b0;
		backpressure_on = 1'b0;
		aborted         = 1'b0;
		pc              = 32'h0000_1000;
		sent            = 0;
		stim_errors     = 0;

		waited = 0;
		while ((rst_n !== 1'b1) && !aborted) begin
			@(posedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				report_timeout("reset release");
			end
		end
		#1;
		@(negedge clk);
		expect_bit("o_res_valid", 1'b0, res_valid);
		expect_bit("o_instr_ready", 1'b1, instr_ready);
		@(posedge clk);
		#1;

		// back-to-back dependent chain at fixed latency
		check_latency = 1'b1;
		send_instr(encode_itype(mips_isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'd5));
		send_instr(encode_itype(mips_isa_pkg::OP_ADDI, 5'd0, 5'd2, 16'hfffd));
		send_instr(encode_rtype(mips_isa_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
		send_instr(encode_rtype(mips_isa_pkg::FN_SUB, 5'd4, 5'd3, 5'd1));
		send_instr(encode_rtype(mips_isa_pkg::FN_AND, 5'd5, 5'd4, 5'd2));
		send_instr(encode_rtype(mips_isa_pkg::FN_OR, 5'd6, 5'd5, 5'd1));
		send_instr(encode_rtype(mips_isa_pkg::FN_SLT, 5'd7, 5'd2, 5'd1));
		send_instr(encode_rtype(mips_isa_pkg::FN_SLT, 5'd8, 5'd1, 5'd2));
		// memory ops and then a read of the load target which must still be zero
		send_instr(encode_itype(mips_isa_pkg::OP_SW, 5'd1, 5'd2, 16'd8));
		send_instr(encode_itype(mips_isa_pkg::OP_LW, 5'd1, 5'd9, 16'hfffc));
		send_instr(encode_rtype(mips_isa_pkg::FN_ADD, 5'd10, 5'd9, 5'd1));
		// taken and not taken branches
		send_instr(encode_itype(mips_isa_pkg::OP_BEQ, 5'd1, 5'd1, 16'd3));
		send_instr(encode_itype(mips_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'hfffe));
		// r0 stays zero and an unknown opcode retires with no flags
		send_instr(encode_itype(mips_isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd7));
		send_instr(encode_rtype(mips_isa_pkg::FN_ADD, 5'd11, 5'd0, 5'd0));
		send_instr(encode_itype(6'h3f, 5'd1, 5'd2, 16'h1234));
		wait_drain();
		check_latency = 1'b0;

		// random traffic with gaps and back-pressure
		backpressure_on = 1'b1;
		for (int n = 0; (n < RANDOM_COUNT) && !aborted; n++) begin
			if (($urandom % 4) == 0) begin
				idle_cycles(int'($urandom % 3) + 1);
			end
			send_instr(random_instr());
		end
		wait_drain();
		backpressure_on = 1'b0;

		$display("sent %0d, retired %0d, checker errors %0d, stimulus errors %0d",
			sent, chk_results, chk_errors, stim_errors);
		if ((chk_errors == 0) && (stim_errors == 0)) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_instr_valid,
	input  logic        i_instr_ready,
	input  logic [31:0] i_instr,
	input  logic [31:0] i_next_pc,
	input  logic        i_res_valid,
	input  logic        i_res_ready,
	input  logic [31:0] i_res_alu,
	input  logic [31:0] i_res_store_data,
	input  logic [4:0]  i_res_dest,
	input  logic        i_res_reg_write,
	input  logic        i_res_mem_read,
	input  logic        i_res_mem_write,
	input  logic        i_res_branch_taken,
	input  logic [31:0] i_res_branch_target,
	input  logic [31:0] i_res_next_pc,
	input  logic        i_check_latency,
	output int          o_results,
	output int          o_errors
);

	logic [31:0] regs_model [32];
	logic [31:0] q_instr [$];
	logic [31:0] q_pc [$];
	int          q_cycle [$];
	int          cycle = 0;
	int          results = 0;
	int          errors = 0;

	assign o_results = results;
	assign o_errors  = errors;

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs_model[i] = '0;
		end
	end

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
	end

	// ========================================================================
	// reference model, one instruction at a time in program order
	// ========================================================================
	function automatic mips_pipe_pkg::res_pkt_t expected_result(input logic [31:0] instr,
		input logic [31:0] next_pc);
		logic [5:0]              op;
		logic [4:0]              rs;
		logic [4:0]              rt;
		logic [4:0]              rd;
		logic [31:0]             a;
		logic [31:0]             b;
		logic [31:0]             imm;
		mips_pipe_pkg::res_pkt_t r;
		op  = instr[31:26];
		rs  = instr[25:21];
		rt  = instr[20:16];
		rd  = instr[15:11];
		imm = {{16{instr[15]}}, instr[15:0]};
		a   = regs_model[rs];
		b   = regs_model[rt];
		// zero control behaves like a plain register add
		r               = '0;
		r.alu           = a + b;
		r.store_data    = b;
		r.dest          = rt;
		r.branch_target = next_pc + (imm << 2);
		r.next_pc       = next_pc;
		case (op)
			mips_isa_pkg::OP_RTYPE: begin
				r.dest      = rd;
				r.reg_write = (rd != 5'd0);
				case (instr[5:0])
					mips_isa_pkg::FN_SUB: r.alu = a - b;
					mips_isa_pkg::FN_AND: r.alu = a & b;
					mips_isa_pkg::FN_OR:  r.alu = a | b;
					mips_isa_pkg::FN_SLT: r.alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:              r.alu = a + b;
				endcase
			end
			mips_isa_pkg::OP_ADDI: begin
				r.alu       = a + imm;
				r.reg_write = (rt != 5'd0);
			end
			mips_isa_pkg::OP_LW: begin
				r.alu      = a + imm;
				r.mem_read = 1'b1;
			end
			mips_isa_pkg::OP_SW: begin
				r.alu       = a + imm;
				r.mem_write = 1'b1;
			end
			mips_isa_pkg::OP_BEQ: begin
				r.alu          = a - b;
				r.branch_taken = (a == b);
			end
			default: begin
			end
		endcase
		return r;
	endfunction

	task automatic check_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_result();
		mips_pipe_pkg::res_pkt_t want;
		int                      accepted_at;
		if (q_instr.size() == 0) begin
			$display("ERROR: a result retired with no instruction in flight");
			errors++;
			return;
		end
		accepted_at = q_cycle.pop_front();
		want = expected_result(q_instr.pop_front(), q_pc.pop_front());
		check_field("o_res_alu", want.alu, i_res_alu);
		check_field("o_res_store_data", want.store_data, i_res_store_data);
		check_field("o_res_dest", 32'(want.dest), 32'(i_res_dest));
		check_field("o_res_reg_write", 32'(want.reg_write), 32'(i_res_reg_write));
		check_field("o_res_mem_read", 32'(want.mem_read), 32'(i_res_mem_read));
		check_field("o_res_mem_write", 32'(want.mem_write), 32'(i_res_mem_write));
		check_field("o_res_branch_taken", 32'(want.branch_taken), 32'(i_res_branch_taken));
		check_field("o_res_branch_target", want.branch_target, i_res_branch_target);
		check_field("o_res_next_pc", want.next_pc, i_res_next_pc);
		if (i_check_latency && (cycle - accepted_at != 2)) begin
			$display("ERROR: result for next_pc %h came %0d cycles after acceptance, not 2",
				want.next_pc, cycle - accepted_at);
			errors++;
		end
		if (want.reg_write) begin
			regs_model[want.dest] = want.alu;
		end
		results++;
	endtask

	// handshakes sampled mid-cycle, the transfer happens at the next edge
	always @(negedge i_clk) begin
		if (i_rst_n) begin
			if (i_instr_valid && i_instr_ready) begin
				q_instr.push_back(i_instr);
				q_pc.push_back(i_next_pc);
				q_cycle.push_back(cycle);
			end
			if (i_res_valid && i_res_ready) begin
				compare_result();
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 2;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// release just after an edge so no flop sees it at the edge itself
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1;
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- mips_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_top (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	// instruction stream
	input  logic                                i_instr_valid,
	output logic                                o_instr_ready,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_instr,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_next_pc,
	// result stream
	output logic                                o_res_valid,
	input  logic                                i_res_ready,
	output logic [mips_isa_pkg::XLEN-1:0]       o_res_alu,
	output logic [mips_isa_pkg::XLEN-1:0]       o_res_store_data,
	output logic [mips_isa_pkg::REG_ADDR_W-1:0] o_res_dest,
	output logic                                o_res_reg_write,
	output logic                                o_res_mem_read,
	output logic                                o_res_mem_write,
	output logic                                o_res_branch_taken,
	output logic [mips_isa_pkg::XLEN-1:0]       o_res_branch_target,
	output logic [mips_isa_pkg::XLEN-1:0]       o_res_next_pc
);

	logic                                dec_valid;
	logic                                dec_ready;
	mips_pipe_pkg::dec_pkt_t             dec_pkt;
	mips_pipe_pkg::res_pkt_t             res_pkt;
	logic                                wb_en;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] wb_addr;
	logic [mips_isa_pkg::XLEN-1:0]       wb_data;

	decode_stage u_decode (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_valid   (i_instr_valid),
		.o_ready   (o_instr_ready),
		.i_instr   (i_instr),
		.i_next_pc (i_next_pc),
		.i_wb_en   (wb_en),
		.i_wb_addr (wb_addr),
		.i_wb_data (wb_data),
		.o_valid   (dec_valid),
		.i_ready   (dec_ready),
		.o_pkt     (dec_pkt)
	);

	execute_stage u_execute (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_valid   (dec_valid),
		.o_ready   (dec_ready),
		.i_pkt     (dec_pkt),
		.o_valid   (o_res_valid),
		.i_ready   (i_res_ready),
		.o_pkt     (res_pkt),
		.o_wb_en   (wb_en),
		.o_wb_addr (wb_addr),
		.o_wb_data (wb_data)
	);

	// result payload out as plain ports
	assign o_res_alu           = res_pkt.alu;
	assign o_res_store_data    = res_pkt.store_data;
	assign o_res_dest          = res_pkt.dest;
	assign o_res_reg_write     = res_pkt.reg_write;
	assign o_res_mem_read      = res_pkt.mem_read;
	assign o_res_mem_write     = res_pkt.mem_write;
	assign o_res_branch_taken  = res_pkt.branch_taken;
	assign o_res_branch_target = res_pkt.branch_target;
	assign o_res_next_pc       = res_pkt.next_pc;

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_valid,
	output logic                                o_ready,
	input  mips_pipe_pkg::dec_pkt_t             i_pkt,
	output logic                                o_valid,
	input  logic                                i_ready,
	output mips_pipe_pkg::res_pkt_t             o_pkt,
	output logic                                o_wb_en,
	output logic [mips_isa_pkg::REG_ADDR_W-1:0] o_wb_addr,
	output logic [mips_isa_pkg::XLEN-1:0]       o_wb_data
);

	mips_pipe_pkg::alu_fn_t              alu_fn;
	logic [mips_isa_pkg::XLEN-1:0]       op_rs;
	logic [mips_isa_pkg::XLEN-1:0]       op_rt;
	logic [mips_isa_pkg::XLEN-1:0]       op_b;
	logic [mips_isa_pkg::XLEN-1:0]       alu_res;
	logic                                alu_zero;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] dest;
	mips_pipe_pkg::res_pkt_t             res_d;

	// ========================================================================
	// ALU control
	// ========================================================================
	always_comb begin
		case (i_pkt.ctrl.aluop)
			mips_pipe_pkg::ALUOP_ADD: alu_fn = mips_pipe_pkg::ALU_ADD;
			mips_pipe_pkg::ALUOP_IMM: alu_fn = mips_pipe_pkg::ALU_ADD;
			mips_pipe_pkg::ALUOP_SUB: alu_fn = mips_pipe_pkg::ALU_SUB;
			default: begin
				case (i_pkt.funct)
					mips_isa_pkg::FN_SUB: alu_fn = mips_pipe_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND: alu_fn = mips_pipe_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:  alu_fn = mips_pipe_pkg::ALU_OR;
					mips_isa_pkg::FN_SLT: alu_fn = mips_pipe_pkg::ALU_SLT;
					// add and unlisted funct codes
					default:              alu_fn = mips_pipe_pkg::ALU_ADD;
				endcase
			end
		endcase
	end

	// forward from the result that retires this cycle
	assign op_rs = (o_wb_en && (o_wb_addr == i_pkt.rs_idx)) ? o_wb_data : i_pkt.rs_val;
	assign op_rt = (o_wb_en && (o_wb_addr == i_pkt.rt_idx)) ? o_wb_data : i_pkt.rt_val;
	assign op_b  = i_pkt.ctrl.alusrc ? i_pkt.imm_ext : op_rt;

	always_comb begin
		case (alu_fn)
			mips_pipe_pkg::ALU_SUB: alu_res = op_rs - op_b;
			mips_pipe_pkg::ALU_AND: alu_res = op_rs & op_b;
			mips_pipe_pkg::ALU_OR:  alu_res = op_rs | op_b;
			mips_pipe_pkg::ALU_SLT: alu_res = {{(mips_isa_pkg::XLEN-1){1'b0}},
				($signed(op_rs) < $signed(op_b))};
			default:                alu_res = op_rs + op_b;
		endcase
	end

	assign alu_zero = (alu_res == '0);
	assign dest     = i_pkt.ctrl.regdst ? i_pkt.rd_idx : i_pkt.rt_idx;

	// ========================================================================
	// result payload
	// ========================================================================
	always_comb begin
		res_d.alu           = alu_res;
		res_d.store_data    = op_rt;
		res_d.dest          = dest;
		// writes to r0 retire without reg_write
		res_d.reg_write     = i_pkt.ctrl.regwrite && (dest != '0);
		res_d.mem_read      = i_pkt.ctrl.memread;
		res_d.mem_write     = i_pkt.ctrl.memwrite;
		res_d.branch_taken  = i_pkt.ctrl.branch && alu_zero;
		res_d.branch_target = i_pkt.next_pc + {i_pkt.imm_ext[mips_isa_pkg::XLEN-3:0], 2'b00};
		res_d.next_pc       = i_pkt.next_pc;
	end

	stage_reg #(
		.T (mips_pipe_pkg::res_pkt_t)
	) u_res_reg (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.i_data  (res_d),
		.o_valid (o_valid),
		.i_ready (i_ready),
		.o_data  (o_pkt)
	);

	// writeback at the moment of retirement
	assign o_wb_en   = o_valid && i_ready && o_pkt.reg_write;
	assign o_wb_addr = o_pkt.dest;
	assign o_wb_data = o_pkt.alu;

	a_wb_not_r0: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_wb_en |-> (o_wb_addr != '0)
	);

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic                                i_valid,
	output logic                                o_ready,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_instr,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_next_pc,
	input  logic                                i_wb_en,
	input  logic [mips_isa_pkg::REG_ADDR_W-1:0] i_wb_addr,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_wb_data,
	output logic                                o_valid,
	input  logic                                i_ready,
	output mips_pipe_pkg::dec_pkt_t             o_pkt
);

	logic [mips_isa_pkg::OPCODE_W-1:0]   opcode;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rs_idx;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rt_idx;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] rd_idx;
	logic [mips_isa_pkg::IMM_W-1:0]      imm;
	logic [mips_isa_pkg::XLEN-1:0]       rs_val;
	logic [mips_isa_pkg::XLEN-1:0]       rt_val;
	mips_pipe_pkg::ctrl_t                ctrl;
	mips_pipe_pkg::dec_pkt_t             pkt_d;

	// ========================================================================
	// field split
	// ========================================================================
	assign opcode = i_instr[mips_isa_pkg::OPCODE_LSB +: mips_isa_pkg::OPCODE_W];
	assign rs_idx = i_instr[mips_isa_pkg::RS_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign rt_idx = i_instr[mips_isa_pkg::RT_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign rd_idx = i_instr[mips_isa_pkg::RD_LSB +: mips_isa_pkg::REG_ADDR_W];
	assign imm    = i_instr[mips_isa_pkg::IMM_W-1:0];

	main_control u_main_control (
		.i_opcode (opcode),
		.o_ctrl   (ctrl)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (rs_idx),
		.i_rt_addr (rt_idx),
		.i_wr_en   (i_wb_en),
		.i_wr_addr (i_wb_addr),
		.i_wr_data (i_wb_data),
		.o_rs_data (rs_val),
		.o_rt_data (rt_val)
	);

	// collect the payload, immediate sign extended here
	always_comb begin
		pkt_d.ctrl    = ctrl;
		pkt_d.next_pc = i_next_pc;
		pkt_d.rs_val  = rs_val;
		pkt_d.rt_val  = rt_val;
		pkt_d.imm_ext = {{(mips_isa_pkg::XLEN - mips_isa_pkg::IMM_W){imm[mips_isa_pkg::IMM_W-1]}},
			imm};
		pkt_d.rs_idx  = rs_idx;
		pkt_d.rt_idx  = rt_idx;
		pkt_d.rd_idx  = rd_idx;
		pkt_d.funct   = i_instr[mips_isa_pkg::FUNCT_W-1:0];
	end

	stage_reg #(
		.T (mips_pipe_pkg::dec_pkt_t)
	) u_dec_reg (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.i_data  (pkt_d),
		.o_valid (o_valid),
		.i_ready (i_ready),
		.o_data  (o_pkt)
	);

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_valid,
	output logic o_ready,
	input  T     i_data,
	output logic o_valid,
	input  logic i_ready,
	output T     o_data
);

	// ========================================================================
	// one-entry valid/ready slot
	// ========================================================================
	// accept when empty or when the held entry leaves this cycle
	assign o_ready = !o_valid || i_ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else if (o_ready) begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_ready && i_valid) begin
			o_data <= i_data;
		end
	end

	// held entry must not change or drop while downstream stalls
	a_hold_stalled: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_data))
	);

	a_valid_known: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!$isunknown(o_valid)
	);

endmodule

`default_nettype wire

//--- register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank (
	input  logic                                i_clk,
	input  logic                                i_rst_n,
	input  logic [mips_isa_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input  logic [mips_isa_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  logic                                i_wr_en,
	input  logic [mips_isa_pkg::REG_ADDR_W-1:0] i_wr_addr,
	input  logic [mips_isa_pkg::XLEN-1:0]       i_wr_data,
	output logic [mips_isa_pkg::XLEN-1:0]       o_rs_data,
	output logic [mips_isa_pkg::XLEN-1:0]       o_rt_data
);

	logic [mips_isa_pkg::XLEN-1:0] regs [mips_isa_pkg::NUM_REGS];
	logic                          wr_live;

	// r0 is never written
	assign wr_live = i_wr_en && (i_wr_addr != '0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < mips_isa_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// write-through, a read in the write cycle sees the new value
	assign o_rs_data = (wr_live && (i_wr_addr == i_rs_addr)) ? i_wr_data : regs[i_rs_addr];
	assign o_rt_data = (wr_live && (i_wr_addr == i_rt_addr)) ? i_wr_data : regs[i_rt_addr];

	// writeback address must be resolved whenever a write is requested
	a_wr_addr_known: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> !$isunknown(i_wr_addr)
	);

endmodule

`default_nettype wire

//--- main_control.sv
`timescale 1ns/1ps
`default_nettype none

module main_control (
	input  logic [mips_isa_pkg::OPCODE_W-1:0] i_opcode,
	output mips_pipe_pkg::ctrl_t              o_ctrl
);

	// opcode table, anything unknown stays all zero
	always_comb begin
		o_ctrl = '0;
		case (i_opcode)
			mips_isa_pkg::OP_RTYPE: begin
				o_ctrl.regdst   = 1'b1;
				o_ctrl.aluop    = mips_pipe_pkg::ALUOP_FUNCT;
				o_ctrl.regwrite = 1'b1;
			end
			mips_isa_pkg::OP_LW: begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.aluop    = mips_pipe_pkg::ALUOP_ADD;
				o_ctrl.memread  = 1'b1;
				o_ctrl.memtoreg = 1'b1;
				// no load writeback path in this slice
				o_ctrl.regwrite = 1'b0;
			end
			mips_isa_pkg::OP_SW: begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.aluop    = mips_pipe_pkg::ALUOP_ADD;
				o_ctrl.memwrite = 1'b1;
			end
			mips_isa_pkg::OP_BEQ: begin
				o_ctrl.aluop    = mips_pipe_pkg::ALUOP_SUB;
				o_ctrl.branch   = 1'b1;
			end
			mips_isa_pkg::OP_ADDI: begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.aluop    = mips_pipe_pkg::ALUOP_IMM;
				o_ctrl.regwrite = 1'b1;
			end
			default: begin
				o_ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

	// ========================================================================
	// control encodings
	// ========================================================================
	// aluop class as produced by the main decoder
	typedef enum logic [1:0] {
		ALUOP_ADD   = 2'b00,
		ALUOP_SUB   = 2'b01,
		ALUOP_FUNCT = 2'b10,
		ALUOP_IMM   = 2'b11
	} alu_op_t;

	// function actually applied by the ALU
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_fn_t;

	// EX, MEM and WB control bits, 9 bits
	typedef struct packed {
		logic    regdst;
		logic    alusrc;
		alu_op_t aluop;
		logic    branch;
		logic    memread;
		logic    memwrite;
		logic    memtoreg;
		logic    regwrite;
	} ctrl_t;

	// ========================================================================
	// stage payloads
	// ========================================================================
	// decode to execute
	typedef struct packed {
		ctrl_t                                   ctrl;
		logic [mips_isa_pkg::XLEN-1:0]           next_pc;
		logic [mips_isa_pkg::XLEN-1:0]           rs_val;
		logic [mips_isa_pkg::XLEN-1:0]           rt_val;
		logic [mips_isa_pkg::XLEN-1:0]           imm_ext;
		logic [mips_isa_pkg::REG_ADDR_W-1:0]     rs_idx;
		logic [mips_isa_pkg::REG_ADDR_W-1:0]     rt_idx;
		logic [mips_isa_pkg::REG_ADDR_W-1:0]     rd_idx;
		logic [mips_isa_pkg::FUNCT_W-1:0]        funct;
	} dec_pkt_t;

	// execute result leaving the core
	typedef struct packed {
		logic [mips_isa_pkg::XLEN-1:0]       alu;
		logic [mips_isa_pkg::XLEN-1:0]       store_data;
		logic [mips_isa_pkg::REG_ADDR_W-1:0] dest;
		logic                                reg_write;
		logic                                mem_read;
		logic                                mem_write;
		logic                                branch_taken;
		logic [mips_isa_pkg::XLEN-1:0]       branch_target;
		logic [mips_isa_pkg::XLEN-1:0]       next_pc;
	} res_pkt_t;

endpackage

`default_nettype wire

//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// ========================================================================
	// data path sizes
	// ========================================================================
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// instruction field positions and widths
	localparam int OPCODE_LSB = 26;
	localparam int OPCODE_W   = 6;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;

	// ========================================================================
	// opcodes and R-type funct codes
	// ========================================================================
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'h23;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'h2b;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'h04;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'h08;

	localparam logic [FUNCT_W-1:0] FN_ADD = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_SUB = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_AND = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR  = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_SLT = 6'h2a;

endpackage

`default_nettype wire
